/* common/cpc_pkg.sv */
package cpc_pkg;

  // ============================
  // Bus and colour types
  // ============================
  typedef logic [15:0] cpu_addr_t;  // Z80 address bus
  typedef logic [7:0]  cpu_byte_t;  // Z80 data byte
  typedef logic [4:0]  color_t;     // Hardware colour number
  typedef logic [3:0]  pen_t;       // Palette index

  // Gate-array command, data bits 7:6
  typedef enum logic [1:0] {
    GA_PEN_SELECT = 2'd0,
    GA_COLOR      = 2'd1,
    GA_MODE_ROM   = 2'd2,
    GA_RAM_CONFIG = 2'd3
  } ga_cmd_e;

  // Screen resolution modes
  typedef enum logic [1:0] {
    MODE_0 = 2'd0,  // 160 x 200, 16 colours
    MODE_1 = 2'd1,  // 320 x 200, 4 colours
    MODE_2 = 2'd2,  // 640 x 200, 2 colours
    MODE_3 = 2'd3   // Undocumented
  } screen_mode_e;

  // ============================
  // Timing
  // ============================
  // Clock enable once every 2**(CPU_SPEED+1) cycles
  localparam int CPU_SPEED = 1;

  // ============================
  // Memory map
  // ============================
  localparam int        RAM_DEPTH        = 48 * 1024;  // Banks 0 to 2
  localparam int        VRAM_DEPTH       = 16 * 1024;  // Bank 3, screen
  localparam int        ROM_DEPTH        = 32 * 1024;  // Lower and upper images
  localparam string     ROM_FILE         = "memory/boot.mem";
  localparam cpu_addr_t UPPER_ROM_OFFSET = 16'h8000;   // C000 maps to ROM 4000

  // ============================
  // PPI pages, high address byte
  // ============================
  localparam cpu_byte_t PPI_A_PAGE    = 8'hf4;
  localparam cpu_byte_t PPI_B_PAGE    = 8'hf5;
  localparam cpu_byte_t PPI_C_PAGE    = 8'hf6;
  localparam cpu_byte_t PPI_CTRL_PAGE = 8'hf7;
  localparam cpu_byte_t PPI_B_FIXED   = 8'h1e;  // Brand and refresh bits

endpackage

/* verilog/io_decode.sv */
`timescale 1ns/1ps

module io_decode (
  input  cpc_pkg::cpu_addr_t i_addr,
  input  logic               i_mreq_n,
  input  logic               i_iorq_n,
  input  logic               i_rd_n,
  input  logic               i_wr_n,
  output logic               o_mem_rd,
  output logic               o_mem_wr,
  output logic               o_io_rd,
  output logic               o_io_wr,
  output logic               o_ga_sel,
  output logic               o_rom_bank_sel,
  output logic               o_ppi_a_sel,
  output logic               o_ppi_b_sel,
  output logic               o_ppi_c_sel,
  output logic               o_ppi_ctrl_sel
);

  import cpc_pkg::*;

  logic      ppi_range;  // Below gate array and ROM bank in priority
  cpu_byte_t page;

  // Active-high strobes from the Z80 request lines
  assign o_mem_rd = ~i_mreq_n & ~i_rd_n;
  assign o_mem_wr = ~i_mreq_n & ~i_wr_n;
  assign o_io_rd  = ~i_iorq_n & ~i_rd_n;
  assign o_io_wr  = ~i_iorq_n & ~i_wr_n;

  // Partial decode, gate array wins over everything
  assign page           = i_addr[15:8];
  assign o_ga_sel       = (i_addr[15:14] == 2'b01);
  assign o_rom_bank_sel = ~o_ga_sel & ~i_addr[13];  // Upper ROM select, A13 low
  assign ppi_range      = ~o_ga_sel & i_addr[13];

  assign o_ppi_a_sel    = ppi_range & (page == PPI_A_PAGE);
  assign o_ppi_b_sel    = ppi_range & (page == PPI_B_PAGE);
  assign o_ppi_c_sel    = ppi_range & (page == PPI_C_PAGE);
  assign o_ppi_ctrl_sel = ppi_range & (page == PPI_CTRL_PAGE);

endmodule

/* gate_array/gate_array.sv */
`timescale 1ns/1ps

module gate_array (
  input  logic                  clk_cpu,
  input  logic                  pwr_up_reset_n,
  input  logic                  i_io_wr,
  input  logic                  i_ga_sel,
  input  logic                  i_addr_bit4,
  input  cpc_pkg::cpu_byte_t    i_wdata,
  input  cpc_pkg::pen_t         i_pen_index,
  output logic                  o_cpu_clk_en,
  output cpc_pkg::screen_mode_e o_mode,
  output cpc_pkg::color_t       o_border_color,
  output cpc_pkg::color_t       o_pen_color,
  output logic                  o_int_enable,
  output logic                  o_lo_rom_disable,
  output logic                  o_hi_rom_disable,
  output logic [2:0]            o_ram_bank,
  output logic [2:0]            o_ram_config
);

  import cpc_pkg::*;

  logic             ga_wr;            // Qualified gate-array write
  ga_cmd_e          cmd;
  pen_t             pen;              // Pen addressed by colour writes
  logic             border_selected;  // Colour writes go to border
  color_t           palette [16];
  logic [CPU_SPEED:0] clk_div;

  assign ga_wr = i_io_wr & i_ga_sel;
  assign cmd   = ga_cmd_e'(i_wdata[7:6]);

  // ============================
  // CPU clock enable
  // ============================
  // Pulse on counter wrap, first one 4 cycles out of reset
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      clk_div      <= '0;
      o_cpu_clk_en <= 1'b0;
    end else begin
      clk_div      <= clk_div + 1'b1;
      o_cpu_clk_en <= &clk_div;
    end
  end

  // ============================
  // Command registers
  // ============================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      pen              <= '0;
      border_selected  <= 1'b0;
      o_border_color   <= '0;
      o_mode           <= MODE_0;
      o_int_enable     <= 1'b0;
      o_lo_rom_disable <= 1'b0;  // Both ROMs visible
      o_hi_rom_disable <= 1'b0;
      o_ram_bank       <= '0;
      o_ram_config     <= '0;
      for (int i = 0; i < 16; i++) begin
        palette[i] <= '0;
      end
    end else if (ga_wr) begin
      case (cmd)
        GA_PEN_SELECT: begin
          border_selected <= i_addr_bit4;
          if (!i_wdata[4]) begin  // Bit 4 set means border, keep pen
            pen <= i_wdata[3:0];
          end
        end
        GA_COLOR: begin
          if (border_selected) begin
            o_border_color <= i_wdata[4:0];
          end else begin
            palette[pen] <= i_wdata[4:0];
          end
        end
        GA_MODE_ROM: begin
          o_int_enable     <= i_wdata[4];
          o_hi_rom_disable <= i_wdata[3];  // Upper ROM at C000
          o_lo_rom_disable <= i_wdata[2];  // Lower ROM at 0000
          o_mode           <= screen_mode_e'(i_wdata[1:0]);
        end
        GA_RAM_CONFIG: begin
          o_ram_bank   <= i_wdata[5:3];
          o_ram_config <= i_wdata[2:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Video pipeline lookup, no register
  assign o_pen_color = palette[i_pen_index];

endmodule

/* verilog/io_ports.sv */
`timescale 1ns/1ps

module io_ports (
  input  logic               clk_cpu,
  input  logic               pwr_up_reset_n,
  input  logic               i_io_wr,
  input  logic               i_io_rd,
  input  logic               i_rom_bank_sel,
  input  logic               i_ppi_a_sel,
  input  logic               i_ppi_b_sel,
  input  logic               i_ppi_c_sel,
  input  logic               i_ppi_ctrl_sel,
  input  cpc_pkg::cpu_byte_t i_wdata,
  input  logic               i_vsync,
  input  cpc_pkg::cpu_byte_t i_kbd_row_data,
  output logic [3:0]         o_rom_bank,
  output cpc_pkg::cpu_byte_t o_ppi_a,
  output cpc_pkg::cpu_byte_t o_ppi_c,
  output cpc_pkg::cpu_byte_t o_ppi_control,
  output logic [3:0]         o_kbd_row_sel,
  output cpc_pkg::cpu_byte_t o_io_rd_data
);

  import cpc_pkg::*;

  // ============================
  // Write latches
  // ============================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_rom_bank    <= '0;
      o_ppi_a       <= '0;
      o_ppi_c       <= '0;
      o_ppi_control <= '0;
    end else if (i_io_wr) begin
      if (i_rom_bank_sel) o_rom_bank <= i_wdata[3:0];   // Low nibble only
      if (i_ppi_a_sel)    o_ppi_a <= i_wdata;           // PSG data bus
      if (i_ppi_c_sel)    o_ppi_c <= i_wdata;           // PSG control, kbd row
      if (i_ppi_ctrl_sel) o_ppi_control <= i_wdata;
    end
  end

  // Row strobe for the external keyboard matrix
  assign o_kbd_row_sel = o_ppi_c[3:0];

  // ============================
  // Read byte
  // ============================
  // Lines up with the memory read registers
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_io_rd_data <= '0;
    end else if (i_io_rd && i_ppi_a_sel) begin
      o_io_rd_data <= i_kbd_row_data;
    end else if (i_io_rd && i_ppi_b_sel) begin
      o_io_rd_data <= {PPI_B_FIXED[7:1], i_vsync};  // Frame flyback in bit 0
    end else begin
      o_io_rd_data <= '0;
    end
  end

endmodule

/* memory/memory_map.sv */
`timescale 1ns/1ps

module memory_map (
  input  logic               clk_cpu,
  input  cpc_pkg::cpu_addr_t i_addr,
  input  cpc_pkg::cpu_byte_t i_wdata,
  input  logic               i_mem_rd,
  input  logic               i_mem_wr,
  input  logic               i_io_rd,
  input  logic               i_lo_rom_disable,
  input  logic               i_hi_rom_disable,
  input  cpc_pkg::cpu_byte_t i_io_rd_data,
  output cpc_pkg::cpu_byte_t o_cpu_rdata
);

  import cpc_pkg::*;

  // ============================
  // Arrays
  // ============================
  cpu_byte_t ram  [RAM_DEPTH];   // 0000 to BFFF
  cpu_byte_t vram [VRAM_DEPTH];  // C000 to FFFF
  cpu_byte_t rom  [ROM_DEPTH];   // Lower image then upper image

  initial begin
    $readmemh(ROM_FILE, rom);
  end

  logic [1:0]                     bank;      // 16 KB bank of the address
  logic                           top_bank;
  cpu_addr_t                      rom_addr;
  logic [$clog2(ROM_DEPTH)-1:0]   rom_idx;
  logic [$clog2(VRAM_DEPTH)-1:0]  vram_idx;

  assign bank     = i_addr[15:14];
  assign top_bank = (bank == 2'b11);
  // Upper ROM sits in the second half of the image
  assign rom_addr = i_addr - UPPER_ROM_OFFSET;  // Low 15 bits unchanged in bank 0
  assign rom_idx  = rom_addr[$clog2(ROM_DEPTH)-1:0];
  assign vram_idx = i_addr[$clog2(VRAM_DEPTH)-1:0];

  // Synchronous array ports
  cpu_byte_t ram_q, vram_q, rom_q;

  always_ff @(posedge clk_cpu) begin
    if (i_mem_wr && !top_bank) begin  // ROM overlay never blocks a write
      ram[i_addr] <= i_wdata;
    end
    if (!top_bank) begin
      ram_q <= ram[i_addr];
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_mem_wr && top_bank) begin
      vram[vram_idx] <= i_wdata;
    end
    vram_q <= vram[vram_idx];
  end

  always_ff @(posedge clk_cpu) begin
    rom_q <= rom[rom_idx];
  end

  // ============================
  // Read source
  // ============================
  logic rom_hit, vram_hit;
  logic rd_rom_q, rd_vram_q, rd_ram_q, rd_io_q;  // Pending read source per array

  // Overlay choice for the current address
  always_comb begin
    rom_hit  = 1'b0;
    vram_hit = 1'b0;
    case (bank)
      2'b00: rom_hit = ~i_lo_rom_disable;
      2'b11: begin
        rom_hit  = ~i_hi_rom_disable;
        vram_hit = i_hi_rom_disable;  // Screen RAM once upper ROM is off
      end
      default: begin
      end
    endcase
  end

  // Memory cycle beats an I/O cycle
  always_ff @(posedge clk_cpu) begin
    rd_rom_q  <= i_mem_rd & rom_hit;
    rd_vram_q <= i_mem_rd & vram_hit;
    rd_ram_q  <= i_mem_rd & ~rom_hit & ~vram_hit;
    rd_io_q   <= ~i_mem_rd & i_io_rd;
  end

  // Zero when nothing is being read
  always_comb begin
    o_cpu_rdata = '0;
    if (rd_rom_q) begin
      o_cpu_rdata = rom_q;
    end else if (rd_vram_q) begin
      o_cpu_rdata = vram_q;
    end else if (rd_ram_q) begin
      o_cpu_rdata = ram_q;
    end else if (rd_io_q) begin
      o_cpu_rdata = i_io_rd_data;
    end
  end

endmodule

/* verilog/cpc_chipset.sv */
`timescale 1ns/1ps

module cpc_chipset (
  input  logic                    clk_cpu,
  input  logic                    pwr_up_reset_n,
  // Z80 bus
  input  cpc_pkg::cpu_addr_t      i_addr,
  input  cpc_pkg::cpu_byte_t      i_cpu_wdata,
  input  logic                    i_mreq_n,
  input  logic                    i_iorq_n,
  input  logic                    i_rd_n,
  input  logic                    i_wr_n,
  output cpc_pkg::cpu_byte_t      o_cpu_rdata,
  output logic                    o_cpu_clk_en,
  // External inputs
  input  logic                    i_vsync,
  input  cpc_pkg::cpu_byte_t      i_kbd_row_data,
  input  cpc_pkg::pen_t           i_pen_index,
  // Gate-array state
  output cpc_pkg::screen_mode_e   o_mode,
  output cpc_pkg::color_t         o_border_color,
  output cpc_pkg::color_t         o_pen_color,
  output logic                    o_int_enable,
  output logic [2:0]              o_ram_bank,
  output logic [2:0]              o_ram_config,
  // I/O ports
  output logic [3:0]              o_rom_bank,
  output cpc_pkg::cpu_byte_t      o_ppi_a,
  output cpc_pkg::cpu_byte_t      o_ppi_c,
  output cpc_pkg::cpu_byte_t      o_ppi_control,
  output logic [3:0]              o_kbd_row_sel
);

  import cpc_pkg::*;

  // Bus strobes
  logic mem_rd, mem_wr, io_rd, io_wr;
  // I/O selects
  logic ga_sel, rom_bank_sel;
  logic ppi_a_sel, ppi_b_sel, ppi_c_sel, ppi_ctrl_sel;
  // Cross-block state
  logic      lo_rom_disable, hi_rom_disable;
  cpu_byte_t io_rd_data;  // Registered PPI read byte

  io_decode u_io_decode (
    .i_addr         (i_addr),
    .i_mreq_n       (i_mreq_n),
    .i_iorq_n       (i_iorq_n),
    .i_rd_n         (i_rd_n),
    .i_wr_n         (i_wr_n),
    .o_mem_rd       (mem_rd),
    .o_mem_wr       (mem_wr),
    .o_io_rd        (io_rd),
    .o_io_wr        (io_wr),
    .o_ga_sel       (ga_sel),
    .o_rom_bank_sel (rom_bank_sel),
    .o_ppi_a_sel    (ppi_a_sel),
    .o_ppi_b_sel    (ppi_b_sel),
    .o_ppi_c_sel    (ppi_c_sel),
    .o_ppi_ctrl_sel (ppi_ctrl_sel)
  );

  gate_array u_gate_array (
    .clk_cpu          (clk_cpu),
    .pwr_up_reset_n   (pwr_up_reset_n),
    .i_io_wr          (io_wr),
    .i_ga_sel         (ga_sel),
    .i_addr_bit4      (i_addr[4]),  // Border select on pen command
    .i_wdata          (i_cpu_wdata),
    .i_pen_index      (i_pen_index),
    .o_cpu_clk_en     (o_cpu_clk_en),
    .o_mode           (o_mode),
    .o_border_color   (o_border_color),
    .o_pen_color      (o_pen_color),
    .o_int_enable     (o_int_enable),
    .o_lo_rom_disable (lo_rom_disable),
    .o_hi_rom_disable (hi_rom_disable),
    .o_ram_bank       (o_ram_bank),
    .o_ram_config     (o_ram_config)
  );

  io_ports u_io_ports (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_io_wr        (io_wr),
    .i_io_rd        (io_rd),
    .i_rom_bank_sel (rom_bank_sel),
    .i_ppi_a_sel    (ppi_a_sel),
    .i_ppi_b_sel    (ppi_b_sel),
    .i_ppi_c_sel    (ppi_c_sel),
    .i_ppi_ctrl_sel (ppi_ctrl_sel),
    .i_wdata        (i_cpu_wdata),
    .i_vsync        (i_vsync),
    .i_kbd_row_data (i_kbd_row_data),
    .o_rom_bank     (o_rom_bank),
    .o_ppi_a        (o_ppi_a),
    .o_ppi_c        (o_ppi_c),
    .o_ppi_control  (o_ppi_control),
    .o_kbd_row_sel  (o_kbd_row_sel),
    .o_io_rd_data   (io_rd_data)
  );

  memory_map u_memory_map (
    .clk_cpu          (clk_cpu),
    .i_addr           (i_addr),
    .i_wdata          (i_cpu_wdata),
    .i_mem_rd         (mem_rd),
    .i_mem_wr         (mem_wr),
    .i_io_rd          (io_rd),
    .i_lo_rom_disable (lo_rom_disable),
    .i_hi_rom_disable (hi_rom_disable),
    .i_io_rd_data     (io_rd_data),
    .o_cpu_rdata      (o_cpu_rdata)
  );

endmodule

/* verification/tb_cpc_checks.svh */
`ifndef TB_CPC_CHECKS_SVH
`define TB_CPC_CHECKS_SVH

// ==============================
// Stimulus table
// ==============================
typedef enum logic [2:0] {
  STEP_IO_WR,
  STEP_IO_RD,
  STEP_MEM_WR,
  STEP_MEM_RD,
  STEP_CHECK  // Bus idle, outputs only
} step_kind_e;

typedef struct {
  step_kind_e   kind;
  cpu_addr_t    addr;
  cpu_byte_t    data;
  logic         vsync;
  cpu_byte_t    kbd_row;
  pen_t         pen_index;
  cpu_byte_t    exp_rdata;      // Zero unless a read
  screen_mode_e exp_mode;
  color_t       exp_border;
  color_t       exp_pen_color;  // Palette entry at pen_index
  logic         exp_int;
  logic [2:0]   exp_ram_bank;
  logic [2:0]   exp_ram_config;
  logic [3:0]   exp_rom_bank;
  cpu_byte_t    exp_ppi_a;
  cpu_byte_t    exp_ppi_c;      // Low nibble is also the row select
  cpu_byte_t    exp_ppi_ctrl;
} step_t;

step_t steps [$];

// Expected chipset state as the table grows
color_t       model_palette [16];
color_t       model_border;
screen_mode_e model_mode;
logic         model_int;
logic [2:0]   model_ram_bank;
logic [2:0]   model_ram_config;
logic [3:0]   model_rom_bank;
cpu_byte_t    model_ppi_a;
cpu_byte_t    model_ppi_c;
cpu_byte_t    model_ppi_ctrl;
pen_t         cur_pen;    // Shown on i_pen_index
logic         cur_vsync;
cpu_byte_t    cur_kbd;

// Snapshot of the expected state after this step
task automatic add_step(input step_kind_e kind, input cpu_addr_t addr,
                        input cpu_byte_t data, input cpu_byte_t exp_rdata);
  step_t s;
  s.kind           = kind;
  s.addr           = addr;
  s.data           = data;
  s.vsync          = cur_vsync;
  s.kbd_row        = cur_kbd;
  s.pen_index      = cur_pen;
  s.exp_rdata      = exp_rdata;
  s.exp_mode       = model_mode;
  s.exp_border     = model_border;
  s.exp_pen_color  = model_palette[cur_pen];
  s.exp_int        = model_int;
  s.exp_ram_bank   = model_ram_bank;
  s.exp_ram_config = model_ram_config;
  s.exp_rom_bank   = model_rom_bank;
  s.exp_ppi_a      = model_ppi_a;
  s.exp_ppi_c      = model_ppi_c;
  s.exp_ppi_ctrl   = model_ppi_ctrl;
  steps.push_back(s);
endtask

task automatic build_steps();
  cpu_byte_t rnd;
  cpu_byte_t ram_lo;
  cpu_byte_t ram_mid;
  cpu_byte_t ram_hi;
  foreach (model_palette[n]) begin
    model_palette[n] = '0;
  end
  model_border     = '0;
  model_mode       = MODE_0;
  model_int        = 1'b0;
  model_ram_bank   = '0;
  model_ram_config = '0;
  model_rom_bank   = '0;
  model_ppi_a      = '0;
  model_ppi_c      = '0;
  model_ppi_ctrl   = '0;
  cur_pen          = '0;
  cur_vsync        = 1'b0;
  cur_kbd          = '0;

  add_step(STEP_CHECK, 16'h0000, 8'h00, 8'h00);  // Reset state

  // Every pen gets a random colour
  for (int n = 0; n < 16; n++) begin
    cur_pen = pen_t'(n);
    add_step(STEP_IO_WR, 16'h7f00, {4'h0, cur_pen}, 8'h00);  // A4 clear, pen select
    rnd = random_bits(5);
    model_palette[cur_pen] = rnd[4:0];
    add_step(STEP_IO_WR, 16'h7f00, {3'b010, rnd[4:0]}, 8'h00);
  end
  add_step(STEP_IO_WR, 16'h7f10, 8'h10, 8'h00);  // A4 set, border
  rnd = random_bits(5);
  model_border = rnd[4:0];
  add_step(STEP_IO_WR, 16'h7f00, {3'b010, rnd[4:0]}, 8'h00);
  for (int n = 0; n < 16; n++) begin  // Palette must survive the border write
    cur_pen = pen_t'(n);
    add_step(STEP_CHECK, 16'h0000, 8'h00, 8'h00);
  end

  // Mode, ROM enables, RAM config, ROM bank
  model_mode = MODE_2;
  model_int  = 1'b1;
  add_step(STEP_IO_WR, 16'h7f00, 8'h92, 8'h00);  // Both ROMs stay on
  model_ram_bank   = 3'd5;
  model_ram_config = 3'd2;
  add_step(STEP_IO_WR, 16'h7f00, 8'hea, 8'h00);
  model_rom_bank = 4'h7;
  add_step(STEP_IO_WR, 16'hdf00, 8'ha7, 8'h00);  // A13 clear

  // Overlay with both ROMs on
  add_step(STEP_MEM_RD, 16'h0000, 8'h00, BOOT_LO_0);
  add_step(STEP_MEM_RD, 16'h0001, 8'h00, BOOT_LO_1);
  add_step(STEP_MEM_RD, 16'hc000, 8'h00, BOOT_HI_0);
  add_step(STEP_MEM_RD, 16'hc001, 8'h00, BOOT_HI_1);
  ram_lo  = random_bits(8);
  ram_mid = random_bits(8);
  ram_hi  = random_bits(8);
  add_step(STEP_MEM_WR, 16'h0000, ram_lo, 8'h00);   // Under lower ROM
  add_step(STEP_MEM_WR, 16'h4000, ram_mid, 8'h00);
  add_step(STEP_MEM_WR, 16'hc000, ram_hi, 8'h00);   // Screen bank
  add_step(STEP_MEM_RD, 16'h4000, 8'h00, ram_mid);
  add_step(STEP_MEM_RD, 16'h0000, 8'h00, BOOT_LO_0);
  add_step(STEP_MEM_RD, 16'hc000, 8'h00, BOOT_HI_0);
  add_step(STEP_IO_WR, 16'h7f00, 8'h9e, 8'h00);     // Both ROMs off
  add_step(STEP_MEM_RD, 16'h0000, 8'h00, ram_lo);
  add_step(STEP_MEM_RD, 16'hc000, 8'h00, ram_hi);
  model_mode = MODE_1;
  model_int  = 1'b0;
  add_step(STEP_IO_WR, 16'h7f00, 8'h89, 8'h00);     // Lower ROM back, upper off
  add_step(STEP_MEM_RD, 16'h0000, 8'h00, BOOT_LO_0);
  add_step(STEP_MEM_RD, 16'hc000, 8'h00, ram_hi);

  // ==============================
  // PPI
  // ==============================
  model_ppi_a = random_bits(8);
  add_step(STEP_IO_WR, 16'hf400, model_ppi_a, 8'h00);
  model_ppi_c = random_bits(8);
  add_step(STEP_IO_WR, 16'hf600, model_ppi_c, 8'h00);
  model_ppi_ctrl = 8'h82;
  add_step(STEP_IO_WR, 16'hf700, 8'h82, 8'h00);
  cur_kbd = random_bits(8);
  add_step(STEP_IO_RD, 16'hf400, 8'h00, cur_kbd);  // Row byte passes through
  cur_vsync = 1'b0;
  add_step(STEP_IO_RD, 16'hf500, 8'h00, 8'h1e);
  cur_vsync = 1'b1;
  add_step(STEP_IO_RD, 16'hf500, 8'h00, 8'h1f);    // Flyback in bit 0
  add_step(STEP_CHECK, 16'h0000, 8'h00, 8'h00);
endtask

// ==============================
// Compare tasks
// ==============================
task automatic check_byte(input string name, input cpu_byte_t got, input cpu_byte_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0d ns: %s got 8'h%h expected 8'h%h", $time, name, got, exp);
    stop_with_failure();
  end
endtask

task automatic check_color(input string name, input color_t got, input color_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0d ns: %s got 5'h%h expected 5'h%h", $time, name, got, exp);
    stop_with_failure();
  end
endtask

task automatic check_mode(input string name, input screen_mode_e got,
                          input screen_mode_e exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0d ns: %s got %s expected %s", $time, name,
             got.name(), exp.name());
    stop_with_failure();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
    stop_with_failure();
  end
endtask

`endif

/* verification/tb_cpc_chipset.sv */
`timescale 1ns/1ps

module tb_cpc_chipset;

  import cpc_pkg::*;

  // ==============================
  // Timing and boot image
  // ==============================
  localparam int CLK_PERIOD      = 100;  // ns
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_STEP = 3;    // Two held, one released
  localparam int CLK_EN_WINDOW   = 40;
  localparam cpu_byte_t BOOT_LO_0 = 8'h01;  // boot.mem @0000
  localparam cpu_byte_t BOOT_LO_1 = 8'h89;
  localparam cpu_byte_t BOOT_HI_0 = 8'h80;  // boot.mem @4000
  localparam cpu_byte_t BOOT_HI_1 = 8'h01;

  logic         clk_cpu = 1'b0;
  logic         pwr_up_reset_n;
  cpu_addr_t    i_addr;
  cpu_byte_t    i_cpu_wdata;
  logic         i_mreq_n;
  logic         i_iorq_n;
  logic         i_rd_n;
  logic         i_wr_n;
  logic         i_vsync;
  cpu_byte_t    i_kbd_row_data;
  pen_t         i_pen_index;
  cpu_byte_t    o_cpu_rdata;
  logic         o_cpu_clk_en;
  screen_mode_e o_mode;
  color_t       o_border_color;
  color_t       o_pen_color;
  logic         o_int_enable;
  logic [2:0]   o_ram_bank;
  logic [2:0]   o_ram_config;
  logic [3:0]   o_rom_bank;
  cpu_byte_t    o_ppi_a;
  cpu_byte_t    o_ppi_c;
  cpu_byte_t    o_ppi_control;
  logic [3:0]   o_kbd_row_sel;

  logic         steps_ready = 1'b0;      // Table built, watchdog may start
  logic [31:0]  lfsr_state  = 32'h282f;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // One step per bit taken, right aligned
  function automatic cpu_byte_t random_bits(input int n);
    cpu_byte_t b;
    b = '0;
    for (int i = 0; i < n; i++) begin
      b = {b[6:0], lfsr_step()};
    end
    return b;
  endfunction

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tb_cpc_checks.svh"

  cpc_chipset DUT (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_addr         (i_addr),
    .i_cpu_wdata    (i_cpu_wdata),
    .i_mreq_n       (i_mreq_n),
    .i_iorq_n       (i_iorq_n),
    .i_rd_n         (i_rd_n),
    .i_wr_n         (i_wr_n),
    .o_cpu_rdata    (o_cpu_rdata),
    .o_cpu_clk_en   (o_cpu_clk_en),
    .i_vsync        (i_vsync),
    .i_kbd_row_data (i_kbd_row_data),
    .i_pen_index    (i_pen_index),
    .o_mode         (o_mode),
    .o_border_color (o_border_color),
    .o_pen_color    (o_pen_color),
    .o_int_enable   (o_int_enable),
    .o_ram_bank     (o_ram_bank),
    .o_ram_config   (o_ram_config),
    .o_rom_bank     (o_rom_bank),
    .o_ppi_a        (o_ppi_a),
    .o_ppi_c        (o_ppi_c),
    .o_ppi_control  (o_ppi_control),
    .o_kbd_row_sel  (o_kbd_row_sel)
  );

  always #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;

  // ==============================
  // Step driver
  // ==============================
  task automatic apply_step(input step_t s);
    cpu_byte_t rdata;
    @(posedge clk_cpu);
    i_addr         <= s.addr;
    i_cpu_wdata    <= s.data;
    i_vsync        <= s.vsync;
    i_kbd_row_data <= s.kbd_row;
    i_pen_index    <= s.pen_index;
    case (s.kind)
      STEP_IO_WR: begin
        i_iorq_n <= 1'b0;
        i_wr_n   <= 1'b0;
      end
      STEP_IO_RD: begin
        i_iorq_n <= 1'b0;
        i_rd_n   <= 1'b0;
      end
      STEP_MEM_WR: begin
        i_mreq_n <= 1'b0;
        i_wr_n   <= 1'b0;
      end
      STEP_MEM_RD: begin
        i_mreq_n <= 1'b0;
        i_rd_n   <= 1'b0;
      end
      default: begin  // Idle bus
      end
    endcase
    @(posedge clk_cpu);
    @(negedge clk_cpu);
    rdata = o_cpu_rdata;  // One cycle after the strobe was sampled
    @(posedge clk_cpu);
    i_mreq_n <= 1'b1;
    i_iorq_n <= 1'b1;
    i_rd_n   <= 1'b1;
    i_wr_n   <= 1'b1;
    @(negedge clk_cpu);
    check_byte("o_cpu_rdata", rdata, s.exp_rdata);
    check_mode("o_mode", o_mode, s.exp_mode);
    check_color("o_border_color", o_border_color, s.exp_border);
    check_color("o_pen_color", o_pen_color, s.exp_pen_color);
    check_bit("o_int_enable", o_int_enable, s.exp_int);
    check_byte("o_ram_bank", {5'b0, o_ram_bank}, {5'b0, s.exp_ram_bank});
    check_byte("o_ram_config", {5'b0, o_ram_config}, {5'b0, s.exp_ram_config});
    check_byte("o_rom_bank", {4'b0, o_rom_bank}, {4'b0, s.exp_rom_bank});
    check_byte("o_ppi_a", o_ppi_a, s.exp_ppi_a);
    check_byte("o_ppi_c", o_ppi_c, s.exp_ppi_c);
    check_byte("o_ppi_control", o_ppi_control, s.exp_ppi_ctrl);
    check_byte("o_kbd_row_sel", {4'b0, o_kbd_row_sel}, {4'b0, s.exp_ppi_c[3:0]});
  endtask

  // Twice the expected run length
  initial begin
    int limit_ns;
    wait (steps_ready);
    limit_ns = (steps.size() * CYCLES_PER_STEP + CLK_EN_WINDOW) * CLK_PERIOD * 2
               + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("Watchdog timeout: the stimulus table did not finish within %0d ns", limit_ns);
    stop_with_failure();
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    cpu_byte_t clk_en_count;
    cpu_byte_t first_pulse;
    pwr_up_reset_n <= 1'b0;
    i_addr         <= '0;
    i_cpu_wdata    <= '0;
    i_mreq_n       <= 1'b1;
    i_iorq_n       <= 1'b1;
    i_rd_n         <= 1'b1;
    i_wr_n         <= 1'b1;
    i_vsync        <= 1'b0;
    i_kbd_row_data <= '0;
    i_pen_index    <= '0;
    build_steps();
    steps_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_cpu);
    pwr_up_reset_n <= 1'b1;

    // Clock enable cadence, cycle 0 is the release edge
    clk_en_count = '0;
    first_pulse  = '0;
    for (int j = 0; j <= CLK_EN_WINDOW; j++) begin
      @(negedge clk_cpu);
      if (o_cpu_clk_en) begin
        if (j > 0) clk_en_count = clk_en_count + 8'd1;
        if (first_pulse == 8'd0) first_pulse = 8'(j);
      end
    end
    check_byte("o_cpu_clk_en first pulse cycle", first_pulse, 8'd4);
    check_byte("o_cpu_clk_en pulses in 40 cycles", clk_en_count, 8'd10);

    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

/* memory/boot.mem */
// ROM image for the test, one hex byte per word
// @0000 lower ROM seen at 0000, @4000 upper ROM seen at C000
@0000
01
89
7f
ed
49
c3
91
05
@4000
80
01
00
00
2a
00
c0

/* build.f */
+incdir+verification
common/cpc_pkg.sv
verilog/io_decode.sv
gate_array/gate_array.sv
verilog/io_ports.sv
memory/memory_map.sv
verilog/cpc_chipset.sv
verification/tb_cpc_chipset.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_cpc_chipset -Mdir obj_dir

sim_out=$(./obj_dir/Vtb_cpc_chipset 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
